//--- common/cacheGeometryPkg.sv
`default_nettype none

package cacheGeometryPkg;

    // Byte address and data word widths
    localparam int addrWidth = 64;
    localparam int wordWidth = 64;

    // 64-byte line of eight 64-bit words
    localparam int offsetBits = 6;
    localparam int wordsPerLine = 8;
    localparam int wordSelBits = 3;

    // Full byte address as seen by core and memory
    typedef logic [addrWidth-1:0] addrT;

    // One data word
    typedef logic [wordWidth-1:0] wordT;

    // Whole cache line, word 0 in the lowest slot
    typedef wordT [wordsPerLine-1:0] lineT;

    // Fill beat counter, also the word select within a line
    typedef logic [wordSelBits-1:0] beatCountT;

endpackage

`default_nettype wire

//--- common/cacheControlPkg.sv
`default_nettype none

package cacheControlPkg;

    // Controller states, one request in flight at a time
    typedef enum logic [2:0] {
        idle,
        lookup,
        compare,
        fillRequest,
        fillWait,
        writeThrough,
        respond
    } ctrlStateT;

    // Way 0 or way 1
    typedef logic wayT;

endpackage

`default_nettype wire

//--- common/wayArrayIf.sv
`timescale 1ns/1ps
`default_nettype none

interface wayArrayIf
    import cacheGeometryPkg::*, cacheControlPkg::*;
#(
    parameter int indexBits = 4
) ();

    localparam int tagBits = addrWidth - indexBits - offsetBits;

    // Controller to array
    logic [indexBits-1:0]    index;
    logic [tagBits-1:0]      writeTag;
    wayT                     writeWay;
    logic                    writeTagEn;
    lineT                    writeLine;
    logic [wordsPerLine-1:0] writeWordEn;
    logic                    touchEn;
    wayT                     touchWay;

    // Array to controller, valid one cycle after index
    logic hit;
    wayT  hitWay;
    wayT  victimWay;
    lineT hitLine;

    modport controller (
        output index, writeTag, writeWay, writeTagEn, writeLine, writeWordEn, touchEn, touchWay,
        input  hit, hitWay, victimWay, hitLine
    );

    modport array (
        input  index, writeTag, writeWay, writeTagEn, writeLine, writeWordEn, touchEn, touchWay,
        output hit, hitWay, victimWay, hitLine
    );

endinterface

`default_nettype wire

//--- rtl/lineFillBuffer.sv
`timescale 1ns/1ps
`default_nettype none

module lineFillBuffer
    import cacheGeometryPkg::*;
(
    input  wire logic rwArbiterCacheBus,
    input  wire logic rstN,
    input  wire logic clear,
    input  wire logic beatValid,
    input  wire wordT beatData,
    output lineT      line,
    output logic      lastBeat
);

    // Number of beats captured so far in this fill
    beatCountT beatCount;

    always_ff @(posedge rwArbiterCacheBus) begin
        if (!rstN) begin
            beatCount <= '0;
        end else if (clear) begin
            beatCount <= '0;
        end else if (beatValid) begin
            // Wraps to zero after the eighth beat
            beatCount <= beatCount + 1'b1;
        end
    end

    // Beats arrive in address order, so the count is the word slot
    always_ff @(posedge rwArbiterCacheBus) begin
        if (beatValid) begin
            line[beatCount] <= beatData;
        end
    end

    // Eighth beat is on beatData this cycle
    assign lastBeat = beatValid && (beatCount == beatCountT'(wordsPerLine - 1));

endmodule

`default_nettype wire

//--- rtl/wayArray/wayArray.sv
`timescale 1ns/1ps
`default_nettype none

module wayArray
    import cacheGeometryPkg::*, cacheControlPkg::*;
#(
    parameter int indexBits = 4
) (
    input  wire logic rwArbiterCacheBus,
    input  wire logic rstN,
    wayArrayIf.array  arrayBus
);

    localparam int tagBits = addrWidth - indexBits - offsetBits;
    localparam int numSets = 1 << indexBits;

    typedef logic [tagBits-1:0] tagT;

    // Storage for both ways
    tagT  tagMem [2][numSets];
    lineT lineMem [2][numSets];
    logic [numSets-1:0] validBits [2];
    // Most recently used way per set
    logic [numSets-1:0] mruBits;

    // Registered read of the addressed set
    tagT  tagQ [2];
    logic validQ [2];
    lineT lineQ [2];
    wayT  mruQ;
    tagT  lookupTagQ;

    logic [1:0] wayHit;

    always_ff @(posedge rwArbiterCacheBus) begin
        for (int w = 0; w < 2; w++) begin
            if (arrayBus.writeWay == wayT'(w)) begin
                if (arrayBus.writeTagEn) begin
                    tagMem[w][arrayBus.index] <= arrayBus.writeTag;
                end
                // Per-word enables
                for (int i = 0; i < wordsPerLine; i++) begin
                    if (arrayBus.writeWordEn[i]) begin
                        lineMem[w][arrayBus.index][i] <= arrayBus.writeLine[i];
                    end
                end
            end
        end
    end

    always_ff @(posedge rwArbiterCacheBus) begin
        if (!rstN) begin
            validBits[0] <= '0;
            validBits[1] <= '0;
            mruBits <= '0;
        end else begin
            // A tag write means a full line just arrived
            if (arrayBus.writeTagEn) begin
                validBits[arrayBus.writeWay][arrayBus.index] <= 1'b1;
            end
            if (arrayBus.touchEn) begin
                mruBits[arrayBus.index] <= arrayBus.touchWay;
            end
        end
    end

    always_ff @(posedge rwArbiterCacheBus) begin
        for (int w = 0; w < 2; w++) begin
            tagQ[w] <= tagMem[w][arrayBus.index];
            validQ[w] <= validBits[w][arrayBus.index];
            lineQ[w] <= lineMem[w][arrayBus.index];
        end
        mruQ <= mruBits[arrayBus.index];
        // Tag to compare, sampled with the set
        lookupTagQ <= arrayBus.writeTag;
    end

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            wayHit[w] = validQ[w] && (tagQ[w] == lookupTagQ);
        end
    end

    assign arrayBus.hit = |wayHit;
    // Way 0 wins, both ways never hold the same tag
    assign arrayBus.hitWay = ~wayHit[0];
    assign arrayBus.hitLine = lineQ[arrayBus.hitWay];

    // First invalid way, otherwise the least recently used one
    always_comb begin
        if (!validQ[0]) begin
            arrayBus.victimWay = 1'b0;
        end else if (!validQ[1]) begin
            arrayBus.victimWay = 1'b1;
        end else begin
            arrayBus.victimWay = ~mruQ;
        end
    end

endmodule

`default_nettype wire

//--- rtl/cacheController/cacheController.sv
`timescale 1ns/1ps
`default_nettype none

module cacheController
    import cacheGeometryPkg::*, cacheControlPkg::*;
#(
    parameter int indexBits = 4
) (
    input  wire logic      rwArbiterCacheBus,
    input  wire logic      rstN,

    // Core side
    input  wire logic      coreReqCyc,
    input  wire addrT      coreReqAddr,
    input  wire logic      coreReqWrite,
    input  wire wordT      coreReqData,
    input  wire logic      coreRespAck,
    output logic           coreReqAck,
    output wordT           coreResp,
    output logic           coreRespCyc,

    // Memory side
    output logic           memReqCyc,
    output addrT           memReqAddr,
    output logic           memReqWrite,
    output wordT           memReqData,
    input  wire logic      memReqAck,
    input  wire logic      memRespCyc,
    input  wire wordT      memResp,

    wayArrayIf.controller  arrayBus,

    // Fill buffer
    output logic           fillClear,
    output logic           fillBeatValid,
    input  wire lineT      fillLine,
    input  wire logic      fillLastBeat
);

    localparam int tagBits = addrWidth - indexBits - offsetBits;

    ctrlStateT state;

    // Latched request
    addrT reqAddr;
    logic reqWrite;
    wordT reqData;

    beatCountT reqWordSel;

    assign reqWordSel = reqAddr[offsetBits-1 -: wordSelBits];

    // Index and tag come from the latched address, stable for the whole request
    assign arrayBus.index = reqAddr[offsetBits +: indexBits];
    assign arrayBus.writeTag = reqAddr[addrWidth-1 -: tagBits];

    // Writes only ever touch one word, fills replace the whole line
    assign arrayBus.writeLine = reqWrite ? {wordsPerLine{reqData}} : fillLine;

    // Counter restart while the miss is decided
    assign fillClear = (state == compare);
    assign fillBeatValid = memRespCyc && ((state == fillRequest) || (state == fillWait));

    always_ff @(posedge rwArbiterCacheBus) begin
        if (!rstN) begin
            state <= idle;
            coreReqAck <= 1'b0;
            coreRespCyc <= 1'b0;
            memReqCyc <= 1'b0;
            arrayBus.writeTagEn <= 1'b0;
            arrayBus.writeWordEn <= '0;
            arrayBus.touchEn <= 1'b0;
        end else begin
            // Single-cycle strobes
            coreReqAck <= 1'b0;
            arrayBus.writeTagEn <= 1'b0;
            arrayBus.writeWordEn <= '0;
            arrayBus.touchEn <= 1'b0;

            case (state)
                idle: begin
                    if (coreReqCyc) begin
                        coreReqAck <= 1'b1;
                        reqAddr <= coreReqAddr;
                        reqWrite <= coreReqWrite;
                        reqData <= coreReqData;
                        state <= lookup;
                    end
                end

                // Array samples the set here
                lookup: begin
                    state <= compare;
                end

                compare: begin
                    if (reqWrite) begin
                        // Update the cached copy only on a hit, no allocate
                        if (arrayBus.hit) begin
                            arrayBus.writeWay <= arrayBus.hitWay;
                            arrayBus.writeWordEn <=
                                {{(wordsPerLine-1){1'b0}}, 1'b1} << reqWordSel;
                        end
                        memReqCyc <= 1'b1;
                        memReqWrite <= 1'b1;
                        memReqAddr <= reqAddr;
                        memReqData <= reqData;
                        state <= writeThrough;
                    end else if (arrayBus.hit) begin
                        arrayBus.touchEn <= 1'b1;
                        arrayBus.touchWay <= arrayBus.hitWay;
                        coreResp <= arrayBus.hitLine[reqWordSel];
                        coreRespCyc <= 1'b1;
                        state <= respond;
                    end else begin
                        // Line-aligned read of the missing line
                        memReqCyc <= 1'b1;
                        memReqWrite <= 1'b0;
                        memReqAddr <= {reqAddr[addrWidth-1:offsetBits], {offsetBits{1'b0}}};
                        state <= fillRequest;
                    end
                end

                // Beats may start as soon as the request is out
                fillRequest, fillWait: begin
                    if (state == fillRequest && memReqAck) begin
                        memReqCyc <= 1'b0;
                        state <= fillWait;
                    end
                    if (fillLastBeat) begin
                        // Refill lands in the victim way next cycle
                        arrayBus.writeWay <= arrayBus.victimWay;
                        arrayBus.writeTagEn <= 1'b1;
                        arrayBus.writeWordEn <= '1;
                        arrayBus.touchEn <= 1'b1;
                        arrayBus.touchWay <= arrayBus.victimWay;
                        // Last word is still on the bus, not yet in the buffer
                        if (reqWordSel == beatCountT'(wordsPerLine - 1)) begin
                            coreResp <= memResp;
                        end else begin
                            coreResp <= fillLine[reqWordSel];
                        end
                        coreRespCyc <= 1'b1;
                        state <= respond;
                    end
                end

                writeThrough: begin
                    if (memReqAck) begin
                        memReqCyc <= 1'b0;
                        coreResp <= reqData;
                        coreRespCyc <= 1'b1;
                        state <= respond;
                    end
                end

                // Hold the response until the core takes it
                respond: begin
                    if (coreRespAck) begin
                        coreRespCyc <= 1'b0;
                        state <= idle;
                    end
                end

                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/dataCacheTop.sv
`timescale 1ns/1ps
`default_nettype none

module dataCacheTop
    import cacheGeometryPkg::*;
#(
    parameter int indexBits = 4
) (
    input  wire logic rwArbiterCacheBus,
    input  wire logic rstN,

    // Core side
    input  wire logic coreReqCyc,
    input  wire addrT coreReqAddr,
    input  wire logic coreReqWrite,
    input  wire wordT coreReqData,
    input  wire logic coreRespAck,
    output logic      coreReqAck,
    output wordT      coreResp,
    output logic      coreRespCyc,

    // Memory arbiter side
    output logic      memReqCyc,
    output addrT      memReqAddr,
    output logic      memReqWrite,
    output wordT      memReqData,
    input  wire logic memReqAck,
    input  wire logic memRespCyc,
    input  wire wordT memResp
);

    // Fill buffer handshake
    logic fillClear;
    logic fillBeatValid;
    lineT fillLine;
    logic fillLastBeat;

    wayArrayIf #(.indexBits(indexBits)) wayBus ();

    cacheController #(.indexBits(indexBits)) i_controller (
        .rwArbiterCacheBus(rwArbiterCacheBus),
        .rstN            (rstN),
        .coreReqCyc      (coreReqCyc),
        .coreReqAddr     (coreReqAddr),
        .coreReqWrite    (coreReqWrite),
        .coreReqData     (coreReqData),
        .coreRespAck     (coreRespAck),
        .coreReqAck      (coreReqAck),
        .coreResp        (coreResp),
        .coreRespCyc     (coreRespCyc),
        .memReqCyc       (memReqCyc),
        .memReqAddr      (memReqAddr),
        .memReqWrite     (memReqWrite),
        .memReqData      (memReqData),
        .memReqAck       (memReqAck),
        .memRespCyc      (memRespCyc),
        .memResp         (memResp),
        .arrayBus        (wayBus.controller),
        .fillClear       (fillClear),
        .fillBeatValid   (fillBeatValid),
        .fillLine        (fillLine),
        .fillLastBeat    (fillLastBeat)
    );

    wayArray #(.indexBits(indexBits)) i_wayArray (
        .rwArbiterCacheBus(rwArbiterCacheBus),
        .rstN            (rstN),
        .arrayBus        (wayBus.array)
    );

    // Beats go straight from memory into the fill buffer
    lineFillBuffer i_fillBuffer (
        .rwArbiterCacheBus(rwArbiterCacheBus),
        .rstN            (rstN),
        .clear           (fillClear),
        .beatValid       (fillBeatValid),
        .beatData        (memResp),
        .line            (fillLine),
        .lastBeat        (fillLastBeat)
    );

endmodule

`default_nettype wire

//--- tb/arbiterMemoryModel.sv
`timescale 1ns/1ps
`default_nettype none

module arbiterMemoryModel
    import cacheGeometryPkg::*;
(
    input  wire logic rwArbiterCacheBus,
    input  wire logic rstN,
    input  wire logic memReqCyc,
    input  wire addrT memReqAddr,
    input  wire logic memReqWrite,
    input  wire wordT memReqData,
    output logic      memReqAck,
    output logic      memRespCyc,
    output wordT      memResp,
    // Traffic seen so far, for the checks in the testbench
    output int        readCount,
    output int        writeCount,
    output addrT      lastAddr,
    output wordT      lastData
);

    typedef enum logic [1:0] {
        waitReq,
        stall,
        ackDone,
        sendBeats
    } memStateT;

    memStateT state;
    integer seed = 21;

    // Only written words are stored, the rest follow the fill pattern
    wordT memWords [addrT];

    // Driven from time zero on
    logic ackQ = 1'b0;
    logic respCycQ = 1'b0;
    wordT respDataQ = '0;

    int stallLeft;
    int beatGap;
    beatCountT beatIndex;
    addrT reqAddr;
    logic reqWrite;
    wordT reqData;

    assign memReqAck = ackQ;
    assign memRespCyc = respCycQ;
    assign memResp = respDataQ;

    function automatic wordT readWord(input addrT addr);
        if (memWords.exists(addr)) begin
            return memWords[addr];
        end
        // Halves swapped and scrambled, so every address bit shows
        return {addr[31:0], addr[63:32]} ^ 64'hC3A5_5A3C_0F96_E187;
    endfunction

    always @(posedge rwArbiterCacheBus) begin
        if (!rstN) begin
            state <= waitReq;
            ackQ <= 1'b0;
            respCycQ <= 1'b0;
            readCount <= 0;
            writeCount <= 0;
        end else begin
            respCycQ <= 1'b0;
            case (state)
                waitReq: begin
                    if (memReqCyc) begin
                        reqAddr <= memReqAddr;
                        reqWrite <= memReqWrite;
                        reqData <= memReqData;
                        stallLeft <= $unsigned($random(seed)) % 4;
                        state <= stall;
                    end
                end
                // Random wait before the acknowledge
                stall: begin
                    if (stallLeft == 0) begin
                        ackQ <= 1'b1;
                        lastAddr <= reqAddr;
                        lastData <= reqData;
                        if (reqWrite) begin
                            memWords[reqAddr] = reqData;
                            writeCount <= writeCount + 1;
                        end else begin
                            readCount <= readCount + 1;
                        end
                        state <= ackDone;
                    end else begin
                        stallLeft <= stallLeft - 1;
                    end
                end
                // Cache drops its request on this edge
                ackDone: begin
                    ackQ <= 1'b0;
                    beatIndex <= '0;
                    beatGap <= $unsigned($random(seed)) % 3;
                    state <= reqWrite ? waitReq : sendBeats;
                end
                // Eight beats in address order, random gaps between them
                sendBeats: begin
                    if (beatGap != 0) begin
                        beatGap <= beatGap - 1;
                    end else begin
                        respCycQ <= 1'b1;
                        respDataQ <= readWord({reqAddr[addrWidth-1:offsetBits], beatIndex, 3'b000});
                        beatIndex <= beatIndex + 1'b1;
                        beatGap <= $unsigned($random(seed)) % 3;
                        if (beatIndex == beatCountT'(wordsPerLine - 1)) begin
                            state <= waitReq;
                        end
                    end
                end
                default: begin
                    state <= waitReq;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- tb/dataCacheTb.sv
`timescale 1ns/1ps
`default_nettype none

module dataCacheTb
    import cacheGeometryPkg::*;
();

    // Four sets only, so lines collide often
    localparam int tbIndexBits = 2;
    localparam int numSets = 1 << tbIndexBits;
    localparam int waitLimit = 100;

    logic rwArbiterCacheBus;
    logic rstN;
    logic coreReqCyc;
    addrT coreReqAddr;
    logic coreReqWrite;
    wordT coreReqData;
    logic coreRespAck;
    logic coreReqAck;
    wordT coreResp;
    logic coreRespCyc;
    logic memReqCyc;
    addrT memReqAddr;
    logic memReqWrite;
    wordT memReqData;
    logic memReqAck;
    logic memRespCyc;
    wordT memResp;
    int   readCount;
    int   writeCount;
    addrT lastAddr;
    wordT lastData;

    integer seed = 21;

    // Reference model, line address stands in for the tag
    addrT refLine [numSets][2];
    logic refValid [numSets][2];
    int   refMru [numSets];
    wordT refMem [addrT];

    initial begin
        rwArbiterCacheBus = 1'b0;
        forever #50 rwArbiterCacheBus = ~rwArbiterCacheBus;
    end

    dataCacheTop #(.indexBits(tbIndexBits)) i_dut (
        .rwArbiterCacheBus(rwArbiterCacheBus),
        .rstN        (rstN),
        .coreReqCyc  (coreReqCyc),
        .coreReqAddr (coreReqAddr),
        .coreReqWrite(coreReqWrite),
        .coreReqData (coreReqData),
        .coreRespAck (coreRespAck),
        .coreReqAck  (coreReqAck),
        .coreResp    (coreResp),
        .coreRespCyc (coreRespCyc),
        .memReqCyc   (memReqCyc),
        .memReqAddr  (memReqAddr),
        .memReqWrite (memReqWrite),
        .memReqData  (memReqData),
        .memReqAck   (memReqAck),
        .memRespCyc  (memRespCyc),
        .memResp     (memResp)
    );

    arbiterMemoryModel i_memory (
        .rwArbiterCacheBus(rwArbiterCacheBus),
        .rstN       (rstN),
        .memReqCyc  (memReqCyc),
        .memReqAddr (memReqAddr),
        .memReqWrite(memReqWrite),
        .memReqData (memReqData),
        .memReqAck  (memReqAck),
        .memRespCyc (memRespCyc),
        .memResp    (memResp),
        .readCount  (readCount),
        .writeCount (writeCount),
        .lastAddr   (lastAddr),
        .lastData   (lastData)
    );

    function automatic wordT expectedWord(input addrT addr);
        if (refMem.exists(addr)) begin
            return refMem[addr];
        end
        return {addr[31:0], addr[63:32]} ^ 64'hC3A5_5A3C_0F96_E187;
    endfunction

    function automatic addrT lineOf(input addrT addr);
        return {addr[addrWidth-1:offsetBits], {offsetBits{1'b0}}};
    endfunction

    function automatic int setOf(input addrT addr);
        return int'(addr[offsetBits +: tbIndexBits]);
    endfunction

    // Way holding the line, -1 on a miss
    function automatic int findWay(input addrT addr);
        for (int w = 0; w < 2; w++) begin
            if (refValid[setOf(addr)][w] && refLine[setOf(addr)][w] == lineOf(addr)) begin
                return w;
            end
        end
        return -1;
    endfunction

    task automatic checkValue(input string testName, input logic [63:0] expected,
                              input logic [63:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected %h actual %h", testName, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "check mismatch");
        end
    endtask

    task automatic reportTimeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Result: FAILED");
        $fatal(1, "wait timed out");
    endtask

    // One core request from drive to response, checked against the model
    task automatic accessCache(input string testName, input addrT addr, input logic write,
                               input wordT data, output logic sawHit);
        int way;
        int s;
        int victim;
        int readsBefore;
        int writesBefore;
        int waitCount;
        int latency;
        wordT got;
        s = setOf(addr);
        way = findWay(addr);
        readsBefore = readCount;
        writesBefore = writeCount;
        @(posedge rwArbiterCacheBus);
        coreReqCyc <= 1'b1;
        coreReqAddr <= addr;
        coreReqWrite <= write;
        coreReqData <= data;
        waitCount = 0;
        @(posedge rwArbiterCacheBus);
        while (coreReqAck !== 1'b1) begin
            if (waitCount >= waitLimit) begin
                reportTimeout({testName, " request acknowledge"});
            end else begin
                waitCount++;
                @(posedge rwArbiterCacheBus);
            end
        end
        coreReqCyc <= 1'b0;
        // Edges from acknowledge to response
        latency = 0;
        while (coreRespCyc !== 1'b1) begin
            if (latency >= waitLimit) begin
                reportTimeout({testName, " core response"});
            end else begin
                latency++;
                @(posedge rwArbiterCacheBus);
            end
        end
        got = coreResp;
        coreRespAck <= 1'b1;
        @(posedge rwArbiterCacheBus);
        coreRespAck <= 1'b0;
        sawHit = (readCount == readsBefore);
        if (write) begin
            checkValue({testName, " memory writes"}, 64'(writesBefore + 1), 64'(writeCount));
            checkValue({testName, " memory reads"}, 64'(readsBefore), 64'(readCount));
            checkValue({testName, " write address"}, addr, lastAddr);
            checkValue({testName, " write data"}, data, lastData);
            refMem[addr] = data;
        end else begin
            checkValue({testName, " read data"}, expectedWord(addr), got);
            checkValue({testName, " memory writes"}, 64'(writesBefore), 64'(writeCount));
            if (way >= 0) begin
                checkValue({testName, " hit"}, 64'd1, 64'(sawHit));
                checkValue({testName, " hit latency"}, 64'd2, 64'(latency));
                refMru[s] = way;
            end else begin
                checkValue({testName, " miss reads"}, 64'(readsBefore + 1), 64'(readCount));
                checkValue({testName, " line address"}, lineOf(addr), lastAddr);
                // First invalid way, else the least recently used
                if (!refValid[s][0]) begin
                    victim = 0;
                end else if (!refValid[s][1]) begin
                    victim = 1;
                end else begin
                    victim = 1 - refMru[s];
                end
                refValid[s][victim] = 1'b1;
                refLine[s][victim] = lineOf(addr);
                refMru[s] = victim;
            end
        end
    endtask

    initial begin
        int i;
        int pick;
        int tagSel;
        int setSel;
        int wordSel;
        logic sawHit;
        addrT addr;
        addrT lines [3];
        wordT data;
        rstN = 1'b0;
        coreReqCyc = 1'b0;
        coreReqAddr = '0;
        coreReqWrite = 1'b0;
        coreReqData = '0;
        coreRespAck = 1'b0;
        for (i = 0; i < numSets; i++) begin
            refValid[i][0] = 1'b0;
            refValid[i][1] = 1'b0;
            refMru[i] = 0;
        end

        // Reset for four edges, outputs quiet during and after
        for (i = 0; i < 7; i++) begin
            @(posedge rwArbiterCacheBus);
            if (i == 3) begin
                rstN <= 1'b1;
            end
            if (i > 0) begin
                checkValue("reset coreReqAck", 64'd0, 64'(coreReqAck));
                checkValue("reset coreRespCyc", 64'd0, 64'(coreRespCyc));
                checkValue("reset memReqCyc", 64'd0, 64'(memReqCyc));
            end
        end

        // First touch of a line, then every word of it again
        accessCache("read miss", 64'h1058, 1'b0, '0, sawHit);
        checkValue("read miss flag", 64'd0, 64'(sawHit));
        for (i = 0; i < wordsPerLine; i++) begin
            accessCache("read hit", 64'h1040 + 64'(i) * 8, 1'b0, '0, sawHit);
            checkValue("read hit flag", 64'd1, 64'(sawHit));
        end

        // Three lines of set 2 in seeded order
        for (i = 0; i < 3; i++) begin
            lines[i] = 64'h2_0080 + 64'(i) * 256;
        end
        for (i = 0; i < 12; i++) begin
            pick = $unsigned($random(seed)) % 3;
            accessCache("replacement", lines[pick], 1'b0, '0, sawHit);
        end

        // Write hit updates the cached word
        accessCache("write hit", 64'h1068, 1'b1, 64'hFEED_0000_1234_5678, sawHit);
        accessCache("write hit readback", 64'h1068, 1'b0, '0, sawHit);
        checkValue("write hit readback flag", 64'd1, 64'(sawHit));
        // Write miss goes around the cache
        accessCache("write miss", 64'h7000_0000_00D0, 1'b1, 64'h0BAD_CAFE_0000_0001, sawHit);
        accessCache("write miss readback", 64'h7000_0000_00D0, 1'b0, '0, sawHit);
        checkValue("write miss no allocate", 64'd0, 64'(sawHit));

        // Mixed traffic over six tags in every set
        for (i = 0; i < 200; i++) begin
            tagSel = $unsigned($random(seed)) % 6;
            setSel = $unsigned($random(seed)) % numSets;
            wordSel = $unsigned($random(seed)) % wordsPerLine;
            addr = 64'hA0_0000_0000 + 64'(tagSel) * 256 + 64'(setSel) * 64 + 64'(wordSel) * 8;
            if ($unsigned($random(seed)) % 3 == 0) begin
                data[63:32] = $random(seed);
                data[31:0] = $random(seed);
                accessCache("random write", addr, 1'b1, data, sawHit);
            end else begin
                accessCache("random read", addr, 1'b0, '0, sawHit);
            end
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
common/cacheGeometryPkg.sv
common/cacheControlPkg.sv
common/wayArrayIf.sv
rtl/lineFillBuffer.sv
rtl/wayArray/wayArray.sv
rtl/cacheController/cacheController.sv
rtl/dataCacheTop.sv
tb/arbiterMemoryModel.sv
tb/dataCacheTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP        = dataCacheTb
FILELIST   = filelist.f
OBJ_DIR    = obj_dir
SIM_FLAGS  = --binary --timing -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
LINT_FLAGS = --lint-only --timing --top-module $(TOP)
PASS_TEXT  = Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
